//--- Bender.yml
package:
  name: cpu_hazard

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/cpu_ins_decode.sv
      - rtl/cpu_hazard_track.sv
      - rtl/cpu_hazard.sv
      - rtl/cpu_hazard_top.sv
  - target: simulation
    files:
      - sim/hazard_checker.sv
      - sim/tb_cpu_hazard.sv

//--- filelist.f
rtl/cpu_pkg.sv
rtl/cpu_ins_decode.sv
rtl/cpu_hazard_track.sv
rtl/cpu_hazard.sv
rtl/cpu_hazard_top.sv
sim/hazard_checker.sv
sim/tb_cpu_hazard.sv

//--- rtl/cpu_hazard.sv
// Hazard comparison, stall counter and issue grant for slot p0.
module cpu_hazard
	import cpu_pkg::*;
#(
	parameter int PIPE_DEPTH = 3
) (
	input  logic                                CLK,
	input  logic                                RSTb,

	input  logic                                is_executing,
	input  logic                                ins_valid,

	input  logic [REG_BITS-1:0]                 reg_a_sel,	// Slot reads.
	input  logic [REG_BITS-1:0]                 reg_b_sel,
	input  logic                                is_branch,

	input  logic [PIPE_DEPTH-1:0][REG_BITS-1:0] hazard_regs,	// In-flight writes.
	input  logic [PIPE_DEPTH-1:0]               flag_bits,

	output logic                                issue,
	output logic                                ins_ready,
	output logic                                stall,
	output logic                                stall_start,
	output logic                                stall_end
);

	localparam int                  CNT_BITS   = $clog2(PIPE_DEPTH + 1);
	localparam logic [CNT_BITS-1:0] STALL_LOAD = CNT_BITS'(PIPE_DEPTH);

	typedef enum logic {
		IDLE,
		STALLING
	} stall_state_t;

	stall_state_t        state;
	logic [CNT_BITS-1:0] count;
	logic                hazard;

	////////////////////////////////////////////////////////////////////////////
	// Hazard detection.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		hazard = 1'b0;
		for (int i = 0; i < PIPE_DEPTH; i++) begin
			if (reg_a_sel != R0 && reg_a_sel == hazard_regs[i])
				hazard = 1'b1;
			if (reg_b_sel != R0 && reg_b_sel == hazard_regs[i])
				hazard = 1'b1;
			if (is_branch && flag_bits[i])
				hazard = 1'b1;	// Branch waits for pending flags.
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stall counter.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: if (hazard) begin
					state <= STALLING;
					count <= STALL_LOAD;
				end
				STALLING: if (is_executing) begin
					count <= count - 1'b1;
					if (count == CNT_BITS'(1))
						state <= IDLE;	// Last bubble goes in this cycle.
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign stall       = (count != '0);
	assign stall_start = (count == STALL_LOAD);
	assign stall_end   = (count == CNT_BITS'(1));

	// Grant only when the pipeline moves and the slot is clean.
	assign ins_ready = is_executing && state == IDLE && !hazard;
	assign issue     = ins_valid && ins_ready;

	a_no_ready_in_stall : assert property (
		@(posedge CLK) disable iff (!RSTb) stall |-> !ins_ready
	) else $error("Issue granted during a stall.");

	a_count_bound : assert property (
		@(posedge CLK) disable iff (!RSTb) count <= STALL_LOAD
	) else $error("Stall count above pipeline depth.");

endmodule

//--- rtl/cpu_hazard_top.sv
// Top level joining the slot decoder, the stage tracker and the hazard unit.
module cpu_hazard_top
	import cpu_pkg::*;
#(
	parameter int PIPE_DEPTH = 3
) (
	input  logic                CLK,
	input  logic                RSTb,

	input  logic                is_executing,
	input  logic                ins_valid,
	input  logic [INS_BITS-1:0] instruction,

	output logic                ins_ready,
	output logic                stall,
	output logic                stall_start,
	output logic                stall_end,
	output logic [REG_BITS-1:0] hazard_reg0,	// Slot write, for observation.
	output logic                modifies_flags0
);

	logic [REG_BITS-1:0]                 reg_a_sel;
	logic [REG_BITS-1:0]                 reg_b_sel;
	logic                                is_branch;
	logic                                issue;
	logic [PIPE_DEPTH-1:0][REG_BITS-1:0] hazard_regs;
	logic [PIPE_DEPTH-1:0]               flag_bits;

	cpu_ins_decode cpu_ins_decode_inst (
		.instruction     (instruction),
		.reg_a_sel       (reg_a_sel),
		.reg_b_sel       (reg_b_sel),
		.hazard_reg0     (hazard_reg0),
		.modifies_flags0 (modifies_flags0),
		.is_branch       (is_branch)
	);

	cpu_hazard_track #(.PIPE_DEPTH(PIPE_DEPTH)) cpu_hazard_track_inst (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.is_executing    (is_executing),
		.issue           (issue),
		.hazard_reg0     (hazard_reg0),
		.modifies_flags0 (modifies_flags0),
		.hazard_regs     (hazard_regs),
		.flag_bits       (flag_bits)
	);

	cpu_hazard #(.PIPE_DEPTH(PIPE_DEPTH)) cpu_hazard_inst (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.is_executing (is_executing),
		.ins_valid    (ins_valid),
		.reg_a_sel    (reg_a_sel),
		.reg_b_sel    (reg_b_sel),
		.is_branch    (is_branch),
		.hazard_regs  (hazard_regs),
		.flag_bits    (flag_bits),
		.issue        (issue),
		.ins_ready    (ins_ready),
		.stall        (stall),
		.stall_start  (stall_start),
		.stall_end    (stall_end)
	);

endmodule

//--- rtl/cpu_hazard_track.sv
// Delay line carrying hazard registers and flag bits through the tracked pipeline stages.
module cpu_hazard_track
	import cpu_pkg::*;
#(
	parameter int PIPE_DEPTH = 3
) (
	input  logic                                CLK,
	input  logic                                RSTb,

	input  logic                                is_executing,	// Pipeline advances.
	input  logic                                issue,	// Slot instruction accepted.
	input  logic [REG_BITS-1:0]                 hazard_reg0,
	input  logic                                modifies_flags0,

	output logic [PIPE_DEPTH-1:0][REG_BITS-1:0] hazard_regs,	// Index 0 is stage 1.
	output logic [PIPE_DEPTH-1:0]               flag_bits
);

	////////////////////////////////////////////////////////////////////////////
	// Stage shift.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			hazard_regs <= '0;
			flag_bits   <= '0;
		end else if (is_executing) begin
			// A bubble enters when nothing issues.
			hazard_regs[0] <= issue ? hazard_reg0 : R0;
			flag_bits[0]   <= issue & modifies_flags0;

			for (int i = 1; i < PIPE_DEPTH; i++) begin
				hazard_regs[i] <= hazard_regs[i-1];
				flag_bits[i]   <= flag_bits[i-1];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks.
	////////////////////////////////////////////////////////////////////////////

	// A bubble leaves no pending write behind it.
	a_bubble_is_r0 : assert property (
		@(posedge CLK) disable iff (!RSTb)
		is_executing && !issue |=> hazard_regs[0] == R0 && !flag_bits[0]
	) else $error("Stage 1 holds a write after a bubble.");

endmodule

//--- rtl/cpu_ins_decode.sv
// Slot instruction decoder for register reads, hazard register and flag write.
module cpu_ins_decode
	import cpu_pkg::*;
(
	input  logic [INS_BITS-1:0] instruction,	// Slot p0 instruction.

	output logic [REG_BITS-1:0] reg_a_sel,	// Destination field when it is read.
	output logic [REG_BITS-1:0] reg_b_sel,	// Source field when it is read.
	output logic [REG_BITS-1:0] hazard_reg0,	// Register this instruction writes.
	output logic                modifies_flags0,
	output logic                is_branch
);

	opcode_t             opcode;
	logic [REG_BITS-1:0] dest;
	logic [REG_BITS-1:0] src;
	logic                variant;

	assign opcode  = opcode_from_ins(instruction);
	assign dest    = reg_dest_from_ins(instruction);
	assign src     = reg_src_from_ins(instruction);
	assign variant = variant_from_ins(instruction);

	////////////////////////////////////////////////////////////////////////////
	// Read and write rules.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Defaults describe a NOP.
		reg_a_sel       = R0;
		reg_b_sel       = R0;
		hazard_reg0     = R0;
		modifies_flags0 = 1'b0;
		is_branch       = 1'b0;

		unique case (opcode)
			OP_ALU_SINGLE: begin
				reg_b_sel       = src;
				hazard_reg0     = src;	// Source doubles as destination.
				modifies_flags0 = 1'b1;
			end
			OP_ALU_REG_REG: begin
				reg_a_sel       = dest;
				reg_b_sel       = src;
				hazard_reg0     = dest;
				modifies_flags0 = 1'b1;
			end
			OP_ALU_REG_IMM: begin
				reg_a_sel       = dest;
				hazard_reg0     = dest;
				modifies_flags0 = 1'b1;
			end
			OP_BRANCH: begin
				reg_b_sel   = src;
				is_branch   = 1'b1;
				hazard_reg0 = variant ? LINK_REGISTER : R0;	// Only a link writes.
			end
			OP_LOAD_STORE, OP_PEEK_POKE: begin
				reg_b_sel = src;
				if (variant) begin
					// Store or poke reads the data register and writes nothing.
					reg_a_sel = dest;
				end else begin
					hazard_reg0 = dest;
				end
			end
			default: begin
				// NOP and unassigned opcodes keep the defaults.
			end
		endcase
	end

endmodule

//--- rtl/cpu_pkg.sv
// Opcode enum, instruction field positions, register constants and field decode functions.
package cpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths.
	////////////////////////////////////////////////////////////////////////////

	localparam int INS_BITS = 16;	// Instruction word.
	localparam int REG_BITS = 4;	// Register select.

	// Field positions inside the instruction word.
	localparam int OPCODE_MSB  = 15;
	localparam int OPCODE_LSB  = 12;
	localparam int VARIANT_BIT = 8;	// Link, store or poke.
	localparam int DEST_MSB    = 7;
	localparam int DEST_LSB    = 4;
	localparam int SRC_MSB     = 3;
	localparam int SRC_LSB     = 0;

	// Special registers.
	localparam logic [REG_BITS-1:0] R0            = 4'd0;	// Hardwired zero that never causes a hazard.
	localparam logic [REG_BITS-1:0] LINK_REGISTER = 4'd15;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes.
	////////////////////////////////////////////////////////////////////////////

	// Values 7 to 15 are unassigned and decode as a NOP.
	typedef enum logic [3:0] {
		OP_NOP         = 4'd0,
		OP_ALU_SINGLE  = 4'd1,
		OP_ALU_REG_REG = 4'd2,
		OP_ALU_REG_IMM = 4'd3,
		OP_BRANCH      = 4'd4,
		OP_LOAD_STORE  = 4'd5,
		OP_PEEK_POKE   = 4'd6
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// Field extraction.
	////////////////////////////////////////////////////////////////////////////

	function automatic opcode_t opcode_from_ins(input logic [INS_BITS-1:0] ins);
		return opcode_t'(ins[OPCODE_MSB:OPCODE_LSB]);
	endfunction

	function automatic logic [REG_BITS-1:0] reg_dest_from_ins(input logic [INS_BITS-1:0] ins);
		return ins[DEST_MSB:DEST_LSB];
	endfunction

	function automatic logic [REG_BITS-1:0] reg_src_from_ins(input logic [INS_BITS-1:0] ins);
		return ins[SRC_MSB:SRC_LSB];
	endfunction

	// Link for a branch, store for load/store, poke for peek/poke.
	function automatic logic variant_from_ins(input logic [INS_BITS-1:0] ins);
		return ins[VARIANT_BIT];
	endfunction

endpackage

//--- sim/hazard_checker.sv
// Reference model of the tracked pipeline, per-cycle output comparison and error counting.
module hazard_checker #(
	parameter int PIPE_DEPTH = 3
) (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic        is_executing,
	input  logic        ins_valid,
	input  logic [15:0] instruction,
	input  logic        ins_ready,
	input  logic        stall,
	input  logic        stall_start,
	input  logic        stall_end,
	input  logic [3:0]  hazard_reg0,
	input  logic        modifies_flags0,
	output int          error_count,
	output int          check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [3:0] reg_q[$];	// Front is stage 1.
	logic       flag_q[$];
	int         count;
	bit         active;	// Set once a reset has been seen.

	// Read and write rules of the instruction set.
	function automatic void ref_decode(input logic [15:0] ins, output logic [3:0] rd_a,
		output logic [3:0] rd_b, output logic [3:0] wr, output logic flags, output logic br);
		logic [3:0] dst;
		logic [3:0] src;
		logic       v;
		dst   = ins[7:4];
		src   = ins[3:0];
		v     = ins[8];
		rd_a  = 4'd0;
		rd_b  = 4'd0;
		wr    = 4'd0;
		flags = 1'b0;
		br    = 1'b0;
		case (ins[15:12])
			4'd1: begin
				rd_b  = src;
				wr    = src;
				flags = 1'b1;
			end
			4'd2: begin
				rd_a  = dst;
				rd_b  = src;
				wr    = dst;
				flags = 1'b1;
			end
			4'd3: begin
				rd_a  = dst;
				wr    = dst;
				flags = 1'b1;
			end
			4'd4: begin
				rd_b = src;
				br   = 1'b1;
				wr   = v ? 4'd15 : 4'd0;
			end
			4'd5, 4'd6: begin
				rd_b = src;
				if (v) rd_a = dst;
				else wr = dst;
			end
			default: ;
		endcase
	endfunction

	task automatic compare(input string name, input logic [3:0] exp, input logic [3:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
		count       = 0;
		active      = 0;
	end

	// Mid-cycle comparison, then the model steps to the coming edge.
	always @(negedge CLK) begin
		logic [3:0] rd_a;
		logic [3:0] rd_b;
		logic [3:0] wr;
		logic       flags;
		logic       br;
		logic       hazard;
		logic       exp_ready;
		ref_decode(instruction, rd_a, rd_b, wr, flags, br);
		hazard = 1'b0;
		foreach (reg_q[i]) begin
			if (rd_a != 0 && rd_a == reg_q[i]) hazard = 1'b1;
			if (rd_b != 0 && rd_b == reg_q[i]) hazard = 1'b1;
			if (br && flag_q[i]) hazard = 1'b1;
		end
		exp_ready = is_executing && count == 0 && !hazard;

		if (active) begin
			compare("hazard_reg0", wr, hazard_reg0);
			compare("modifies_flags0", 4'(flags), 4'(modifies_flags0));
			compare("ins_ready", 4'(exp_ready), 4'(ins_ready));
			compare("stall", 4'(count != 0), 4'(stall));
			compare("stall_start", 4'(count == PIPE_DEPTH), 4'(stall_start));
			compare("stall_end", 4'(count == 1), 4'(stall_end));
		end

		// State after the coming edge.
		if (!RSTb) begin
			reg_q  = {};
			flag_q = {};
			repeat (PIPE_DEPTH) begin
				reg_q.push_back(4'd0);
				flag_q.push_back(1'b0);
			end
			count  = 0;
			active = 1;
		end else if (active) begin
			if (count == 0) begin
				if (hazard) count = PIPE_DEPTH;
			end else if (is_executing) begin
				count--;
			end
			if (is_executing) begin
				void'(reg_q.pop_back());
				void'(flag_q.pop_back());
				reg_q.push_front((ins_valid && exp_ready) ? wr : 4'd0);	// Bubble is R0.
				flag_q.push_front(ins_valid && exp_ready && flags);
			end
		end
	end

endmodule

//--- sim/tb_cpu_hazard.sv
// Testbench top with clock, reset, directed and random instruction stimulus, timeout and DUT.
module tb_cpu_hazard;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PIPE_DEPTH      = 3;
	localparam int RANDOM_INS      = 400;
	localparam int DIRECTED_CYCLES = 80;
	localparam int CYCLE_LIMIT     = (DIRECTED_CYCLES + RANDOM_INS) * (PIPE_DEPTH + 1) * 2;

	logic        CLK;
	logic        RSTb;
	logic        is_executing;
	logic        ins_valid;
	logic [15:0] instruction;
	logic        ins_ready;
	logic        stall;
	logic        stall_start;
	logic        stall_end;
	logic [3:0]  hazard_reg0;
	logic        modifies_flags0;

	int          seed;
	int          cycles;
	int          error_count;
	int          check_count;
	bit          random_mode;

	cpu_hazard_top #(.PIPE_DEPTH(PIPE_DEPTH)) cpu_hazard_top_inst (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.is_executing    (is_executing),
		.ins_valid       (ins_valid),
		.instruction     (instruction),
		.ins_ready       (ins_ready),
		.stall           (stall),
		.stall_start     (stall_start),
		.stall_end       (stall_end),
		.hazard_reg0     (hazard_reg0),
		.modifies_flags0 (modifies_flags0)
	);

	hazard_checker #(.PIPE_DEPTH(PIPE_DEPTH)) hazard_checker_inst (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.is_executing    (is_executing),
		.ins_valid       (ins_valid),
		.instruction     (instruction),
		.ins_ready       (ins_ready),
		.stall           (stall),
		.stall_start     (stall_start),
		.stall_end       (stall_end),
		.hazard_reg0     (hazard_reg0),
		.modifies_flags0 (modifies_flags0),
		.error_count     (error_count),
		.check_count     (check_count)
	);

	always #50 CLK = ~CLK;	// 100 ns period.

	// Run limit.
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] encode(input logic [3:0] op, input logic variant,
		input logic [3:0] dest, input logic [3:0] src);
		return {op, 3'b000, variant, dest, src};
	endfunction

	// Biased toward R0 to R3 so hazards are frequent.
	function automatic logic [3:0] pick_reg();
		if (($random(seed) & 7) < 6)
			return 4'($random(seed) & 3);
		return 4'($random(seed) & 15);
	endfunction

	function automatic logic pick_exec();
		if (!random_mode)
			return 1'b1;
		return (($random(seed) & 7) != 0);	// Low about one cycle in eight.
	endfunction

	// Keeps the slot steady until the handshake edge.
	task automatic wait_issue();
		bit done;
		done = 0;
		while (!done) begin
			@(negedge CLK);
			if (ins_valid && ins_ready)
				done = 1;
			else begin
				@(posedge CLK);
				is_executing <= pick_exec();
			end
		end
	endtask

	task automatic send(input logic [15:0] ins);
		@(posedge CLK);
		instruction  <= ins;
		ins_valid    <= 1'b1;
		is_executing <= pick_exec();
		wait_issue();
	endtask

	task automatic idle_cycle();
		@(posedge CLK);
		ins_valid    <= 1'b0;
		is_executing <= pick_exec();
	endtask

	initial begin
		CLK          = 1'b0;
		RSTb         = 1'b0;
		is_executing = 1'b0;
		ins_valid    = 1'b0;
		instruction  = '0;
		cycles       = 0;
		random_mode  = 0;
		seed         = 32'hb4e5_f0dc;

		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;

		// Decode of every opcode and variant.
		for (int op = 0; op < 16; op++) begin
			for (int v = 0; v < 2; v++)
				send(encode(4'(op), 1'(v), 4'hA, 4'h5));
		end

		// Register hazard on R3.
		send(encode(4'd1, 1'b0, 4'd0, 4'd3));
		send(encode(4'd2, 1'b0, 4'd4, 4'd3));

		// Reads of R0 after writes to R0.
		send(encode(4'd5, 1'b1, 4'd0, 4'd0));
		send(encode(4'd1, 1'b0, 4'd0, 4'd0));
		send(encode(4'd3, 1'b0, 4'd0, 4'd0));

		// Flag hazard, then a branch after enough non-flag instructions.
		send(encode(4'd3, 1'b0, 4'd5, 4'd0));
		send(encode(4'd4, 1'b0, 4'd0, 4'd0));
		send(encode(4'd5, 1'b0, 4'd6, 4'd0));
		send(encode(4'd5, 1'b0, 4'd7, 4'd0));
		send(encode(4'd5, 1'b0, 4'd8, 4'd0));
		send(encode(4'd4, 1'b1, 4'd0, 4'd0));

		// Back-pressure in the middle of a stall.
		send(encode(4'd1, 1'b0, 4'd0, 4'd3));
		@(posedge CLK);
		instruction  <= encode(4'd2, 1'b0, 4'd3, 4'd1);
		ins_valid    <= 1'b1;
		is_executing <= 1'b1;
		@(posedge CLK);
		is_executing <= 1'b0;
		repeat (3) @(posedge CLK);
		is_executing <= 1'b1;
		wait_issue();

		// Random stream.
		random_mode = 1;
		for (int n = 0; n < RANDOM_INS; n++) begin
			if (($random(seed) & 7) == 0)
				idle_cycle();
			send(encode(4'($random(seed) & 7), 1'($random(seed) & 1), pick_reg(), pick_reg()));
		end
		random_mode = 0;
		repeat (PIPE_DEPTH + 2) idle_cycle();
		@(posedge CLK);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
